//--- sim.f
+incdir+verification
common/loopFilterPkg.sv
design/leadGain.sv
lagGain/sweepControl.sv
lagGain/lagGain.sv
design/loopSum.sv
design/loopFilter.sv
verification/loopFilterTb.sv

//--- Bender.yml
package:
  name: loopFilter

sources:
  - common/loopFilterPkg.sv
  - design/leadGain.sv
  - lagGain/sweepControl.sv
  - lagGain/lagGain.sv
  - design/loopSum.sv
  - design/loopFilter.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/loopFilterTb.sv

//--- verification/loopFilterModel.svh
// Loop filter reference model
// Follows both gain paths, the saturating accumulator, the sweep and the
// three-stage pipeline, and queues the words the DUT should produce
`ifndef LOOP_FILTER_MODEL_SVH
`define LOOP_FILTER_MODEL_SVH

longint             mLead1;
longint             mLag1;
longint             mLeadDly;
longint             mAcc;
longint             mOffset;
bit                 mValid1;
bit                 mClear1;
bit                 mSync1;
bit                 mValid2;
bit                 mHitUp;
bit                 mHitLow;
bit                 mDirUp;
// State 0 is off, 1 is up and 2 is down
int                 mState;
logic signed [31:0] expQ[$];

// Track mode cuts the code and a negative result floors at 1
function automatic int effCode(int code, int cut, bit trk);
    int d;
    d = trk ? code - cut : code;
    if (d < 0) begin
        d = 1;
    end
    return d;
endfunction

function automatic longint scaleError(int err, int code);
    longint e;
    e = err;
    if (code == 0) begin
        return 0;
    end
    if (code < 3) begin
        return e >>> (3 - code);
    end
    return e <<< (code - 3);
endfunction

task automatic modelReset();
    mLead1 = 0;
    mLag1 = 0;
    mLeadDly = 0;
    mAcc = 0;
    mOffset = 0;
    {mValid1, mClear1, mSync1, mValid2, mHitUp, mHitLow} = '0;
    mDirUp = 1'b1;
    mState = 0;
    expQ.delete();
endtask

// One pipeline advance with the inputs present at that edge
task automatic modelStep(input bit valid, input errSample s, input loopConfig c);
    longint sum;
    longint top;
    longint outSum;
    longint rate;
    longint oldOff;
    bit     oldUp;
    bit     oldLow;
    oldUp = mHitUp;
    oldLow = mHitLow;
    oldOff = mOffset;
    rate = longint'(c.sweepRateMag);
    // Output stage saturates to 40 bits and keeps the top 32
    if (mValid2) begin
        outSum = mAcc + mLeadDly;
        if (outSum > 64'sh7f_ffff_ffff) begin
            outSum = 64'sh7f_ffff_ffff;
        end
        else if (outSum < -64'sh80_0000_0000) begin
            outSum = -64'sh80_0000_0000;
        end
        expQ.push_back(32'(outSum >>> 8));
    end
    mValid2 = mValid1;
    mLeadDly = mLead1;
    // Accumulator
    if (valid && s.clearAccum) begin
        mAcc = 0;
        mHitUp = 0;
        mHitLow = 0;
    end
    else if (mValid1 && !mClear1) begin
        sum = mAcc + mLag1 + oldOff;
        top = sum >>> 8;
        mHitUp = 0;
        mHitLow = 0;
        if (c.upperLimit < c.lowerLimit) begin
            mAcc = mAcc;
        end
        else if (top >= c.upperLimit) begin
            mAcc = longint'(c.upperLimit) * 256;
            mHitUp = 1;
        end
        else if (top <= c.lowerLimit) begin
            mAcc = longint'(c.lowerLimit) * 256 + 255;
            mHitLow = 1;
        end
        else begin
            mAcc = sum;
        end
    end
    // Sweep steps with the flags from its previous step
    if (mValid1) begin
        if (!c.sweepEnable) begin
            mState = 0;
            mOffset = 0;
            mDirUp = 1;
        end
        else if (mSync1) begin
            if (mState == 1) begin
                mDirUp = 1;
            end
            else if (mState == 2) begin
                mDirUp = 0;
            end
            mState = 0;
            mOffset = 0;
        end
        else if (mState == 0) begin
            mState = mDirUp ? 1 : 2;
            mOffset = mDirUp ? rate : -rate;
        end
        else if (mState == 1) begin
            mOffset = oldUp ? -rate : rate;
            if (oldUp) begin
                mState = 2;
            end
        end
        else begin
            mOffset = oldLow ? rate : -rate;
            if (oldLow) begin
                mState = 1;
            end
        end
    end
    // Input stage
    mValid1 = valid;
    mClear1 = valid && s.clearAccum;
    mSync1 = s.carrierInSync;
    mLead1 = scaleError(s.error, effCode(c.leadExp, c.acqTrackControl, c.track));
    mLag1 = scaleError(s.error, effCode(c.lagExp, 2 * c.acqTrackControl, c.track));
endtask

`endif

//--- verification/loopFilterTb.sv
// Loop filter testbench
// Random samples and back-pressure against the reference model, with
// directed phases for gains, saturation, sweep and clearing
`timescale 1ns/1ps

module loopFilterTb
    import loopFilterPkg::*;
();

    localparam int gainLen     = 200;
    localparam int satLen      = 150;
    localparam int sweepLen    = 240;
    localparam int clearLen    = 100;
    localparam int pressureLen = 300;
    localparam int totalSamples = 1 + gainLen + satLen + sweepLen + clearLen + pressureLen;

    logic               clk;
    logic               reset;
    loopConfig          cfg;
    loopConfig          pendingCfg;
    errSample           sample;
    logic               sampleValid;
    logic               sampleReady;
    logic signed [31:0] freqWord;
    logic               freqValid;
    logic               freqReady;
    integer             seed;
    int                 errors;
    int                 checks;
    int                 accepted;
    int                 taken;
    int                 upperSeen;
    int                 lowerSeen;
    string              testName;

    `include "loopFilterModel.svh"

    loopFilter #(.errWidth(12), .accWidth(40)) dut_i (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .sample     (sample),
        .sampleValid(sampleValid),
        .sampleReady(sampleReady),
        .freqWord   (freqWord),
        .freqValid  (freqValid),
        .freqReady  (freqReady)
    );

    always #50 clk = ~clk;

    initial begin
        repeat (totalSamples * 20) @(posedge clk);
        $display("Watchdog expired in %s, the DUT stopped making progress", testName);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Done: errors found");
        $finish;
    end

    function automatic bit chance(int pct);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return (r % 100) < pct;
    endfunction

    // Edge codes come up often on purpose
    function automatic gainCode pickCode();
        int r;
        r = $random(seed) & 7;
        case (r)
            0: return 5'd0;
            1: return 5'd1;
            2: return 5'd2;
            3: return 5'd31;
            default: return gainCode'($random(seed));
        endcase
    endfunction

    function automatic errSample randomSample(bit zeroErr, int clearPct, int syncPct);
        errSample s;
        s.error = zeroErr ? 12'sd0 : 12'($random(seed));
        s.clearAccum = chance(clearPct);
        s.carrierInSync = chance(syncPct);
        return s;
    endfunction

    function automatic loopConfig baseCfg();
        loopConfig c;
        c = '0;
        c.leadExp = 5'd3;
        c.lagExp = 5'd3;
        c.upperLimit = 32'h7fff_0000;
        c.lowerLimit = 32'h8001_0000;
        return c;
    endfunction

    task automatic randomCodes();
        pendingCfg.leadExp = pickCode();
        pendingCfg.lagExp = pickCode();
        pendingCfg.acqTrackControl = 2'($random(seed));
        pendingCfg.track = 1'($random(seed));
    endtask

    // Drive one cycle, check a word if one is taken, then step the model
    task automatic runCycle(input errSample s, input logic v, input logic rdy);
        logic               adv;
        logic signed [31:0] expWord;
        @(negedge clk);
        cfg = pendingCfg;
        sample = s;
        sampleValid = v;
        freqReady = rdy;
        #10;
        adv = !freqValid || freqReady;
        if (sampleReady !== adv) begin
            errors++;
            $display("%s: sampleReady does not follow the output handshake", testName);
        end
        if (freqValid && freqReady) begin
            taken++;
            if (freqWord === cfg.upperLimit) begin
                upperSeen++;
            end
            if (freqWord === cfg.lowerLimit) begin
                lowerSeen++;
            end
            if (expQ.size() == 0) begin
                errors++;
                $display("%s: freqValid was high with no word expected", testName);
            end
            else begin
                expWord = expQ.pop_front();
                checks++;
                if (freqWord !== expWord) begin
                    errors++;
                    $display("ERR %s expected %h actual %h", testName, expWord, freqWord);
                end
            end
        end
        if (adv) begin
            if (v) begin
                accepted++;
            end
            modelStep(v, s, cfg);
        end
    endtask

    task automatic runRandom(int n, int validPct, int readyPct, bit zeroErr,
                             int clearPct, int syncPct);
        repeat (n) begin
            runCycle(randomSample(zeroErr, clearPct, syncPct), chance(validPct),
                     chance(readyPct));
        end
    endtask

    task automatic drainPipeline();
        int n;
        n = 0;
        while ((expQ.size() != 0 || freqValid) && n < 12) begin
            runCycle('0, 1'b0, 1'b1);
            n++;
        end
        if (expQ.size() != 0) begin
            errors++;
            $display("%s: %0d expected words never appeared", testName, expQ.size());
        end
    endtask

    initial begin
        errSample           first;
        logic signed [31:0] leadOnly;
        int                 latency;
        seed = 32'hc3a3;
        {errors, checks, accepted, taken} = '0;
        upperSeen = 0;
        lowerSeen = 0;
        testName = "reset";
        clk = 1'b0;
        reset = 1'b1;
        pendingCfg = baseCfg();
        cfg = pendingCfg;
        sample = '0;
        sampleValid = 1'b0;
        freqReady = 1'b1;
        modelReset();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (freqValid !== 1'b0 || sampleReady !== 1'b1) begin
            errors++;
            $display("After reset freqValid is not low or sampleReady is not high");
        end

        // Lead path only with the three cycle latency
        testName = "leadOnly";
        pendingCfg.leadExp = 5'd9;
        pendingCfg.lagExp = 5'd0;
        first = randomSample(1'b0, 0, 0);
        leadOnly = 32'((longint'(first.error) <<< 6) >>> 8);
        runCycle(first, 1'b1, 1'b1);
        latency = 0;
        while (!freqValid && latency < 6) begin
            runCycle('0, 1'b0, 1'b1);
            latency++;
        end
        checks++;
        if (freqWord !== leadOnly || latency != 3) begin
            errors++;
            $display("ERR %s expected %h after 3 cycles actual %h after %0d",
                     testName, leadOnly, freqWord, latency);
        end
        drainPipeline();

        testName = "gainScaling";
        for (int i = 0; i < gainLen / 20; i++) begin
            randomCodes();
            runRandom(20, 80, 100, 1'b0, 0, 0);
        end
        drainPipeline();

        testName = "saturation";
        pendingCfg = baseCfg();
        pendingCfg.leadExp = 5'd31;
        pendingCfg.lagExp = 5'd31;
        runRandom(60, 90, 100, 1'b0, 0, 0);
        pendingCfg.upperLimit = $random(seed) & 32'h000f_ffff;
        pendingCfg.lowerLimit = -($random(seed) & 32'h000f_ffff);
        pendingCfg.lagExp = 5'd24;
        runRandom(60, 90, 100, 1'b0, 0, 0);
        // Crossed limits
        pendingCfg.upperLimit = -32'sd100;
        pendingCfg.lowerLimit = 32'sd100;
        runRandom(satLen - 120, 90, 100, 1'b0, 0, 0);
        drainPipeline();

        testName = "sweep";
        pendingCfg = baseCfg();
        pendingCfg.upperLimit = 32'h0004_0000;
        pendingCfg.lowerLimit = -32'sh0004_0000;
        pendingCfg.sweepEnable = 1'b1;
        pendingCfg.sweepRateMag = 32'h0040_0000;
        upperSeen = 0;
        lowerSeen = 0;
        runRandom(160, 100, 100, 1'b1, 0, 0);
        if (upperSeen == 0 || lowerSeen == 0) begin
            errors++;
            $display("sweep: the output did not reach both limits");
        end
        runRandom(20, 100, 100, 1'b1, 0, 100);
        runRandom(sweepLen - 180, 100, 100, 1'b1, 0, 0);
        drainPipeline();

        testName = "clearAccum";
        pendingCfg = baseCfg();
        pendingCfg.lagExp = 5'd8;
        runRandom(clearLen, 80, 100, 1'b0, 15, 0);
        drainPipeline();

        testName = "backPressure";
        pendingCfg = baseCfg();
        pendingCfg.upperLimit = 32'h0010_0000;
        pendingCfg.lowerLimit = -32'sh0010_0000;
        pendingCfg.sweepEnable = 1'b1;
        pendingCfg.sweepRateMag = 32'h0010_0000;
        for (int i = 0; i < pressureLen / 50; i++) begin
            randomCodes();
            runRandom(50, 70, 50, 1'b0, 5, 10);
        end
        drainPipeline();

        if (accepted != taken) begin
            errors++;
            $display("Accepted %0d samples but took %0d words", accepted, taken);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end
        else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- design/loopFilter.sv
// Carrier-recovery loop filter top level
// Feeds each error sample to the lead and lag paths and combines
// them into an NCO frequency word, stalling as a whole on back-pressure
`timescale 1ns/1ps

module loopFilter
    import loopFilterPkg::*;
#(
    parameter int errWidth = 12,
    parameter int accWidth = 40
) (
    input  logic               clk,
    input  logic               reset,
    input  loopConfig          cfg,
    input  errSample           sample,
    input  logic               sampleValid,
    output logic               sampleReady,
    output logic signed [31:0] freqWord,
    output logic               freqValid,
    input  logic               freqReady
);

    logic                       advance;
    logic                       valid1;
    logic                       valid2;
    logic signed [accWidth-1:0] leadTerm;
    logic signed [accWidth-1:0] leadDelay;
    logic signed [accWidth-1:0] lagAccum;

    // Whole pipeline moves only when the output slot is free or being taken
    assign advance     = !freqValid || freqReady;
    assign sampleReady = advance;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
        end
        else if (advance) begin
            valid1 <= sampleValid;
            valid2 <= valid1;
        end
    end

    // Lines the lead term up with the accumulator stage
    always_ff @(posedge clk) begin
        if (advance) begin
            leadDelay <= leadTerm;
        end
    end

    leadGain #(.errWidth(errWidth), .accWidth(accWidth)) lead_i (
        .clk            (clk),
        .reset          (reset),
        .advance        (advance),
        .error          (sample.error),
        .leadExp        (cfg.leadExp),
        .acqTrackControl(cfg.acqTrackControl),
        .track          (cfg.track),
        .leadTerm       (leadTerm)
    );

    lagGain #(.errWidth(errWidth), .accWidth(accWidth)) lag_i (
        .clk     (clk),
        .reset   (reset),
        .advance (advance),
        .inValid (sampleValid),
        .sample  (sample),
        .cfg     (cfg),
        .lagAccum(lagAccum)
    );

    loopSum #(.accWidth(accWidth)) sum_i (
        .clk      (clk),
        .reset    (reset),
        .advance  (advance),
        .inValid  (valid2),
        .leadTerm (leadDelay),
        .lagAccum (lagAccum),
        .freqWord (freqWord),
        .freqValid(freqValid)
    );

endmodule

//--- design/loopSum.sv
// Loop filter output stage
// Adds lead and lag terms, saturates to the accumulator range and
// holds the frequency word for the NCO handshake
`timescale 1ns/1ps

module loopSum #(
    parameter int accWidth = 40
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       advance,
    input  logic                       inValid,
    input  logic signed [accWidth-1:0] leadTerm,
    input  logic signed [accWidth-1:0] lagAccum,
    output logic signed [31:0]         freqWord,
    output logic                       freqValid
);

    logic signed [accWidth:0]   sum;
    logic signed [accWidth-1:0] saturated;

    assign sum = {lagAccum[accWidth-1], lagAccum} + {leadTerm[accWidth-1], leadTerm};

    // Guard bit differs from the sign bit only on overflow
    always_comb begin
        if (sum[accWidth] != sum[accWidth-1]) begin
            saturated = sum[accWidth] ? {1'b1, {(accWidth - 1){1'b0}}}
                                      : {1'b0, {(accWidth - 1){1'b1}}};
        end
        else begin
            saturated = sum[accWidth-1:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            freqValid <= 1'b0;
        end
        else if (advance) begin
            freqValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && inValid) begin
            freqWord <= saturated[accWidth-1 -: 32];
        end
    end

    // A stalled word stays put and stays valid
    wordHeld: assert property (
        @(posedge clk) disable iff (reset)
        (freqValid && !advance) |=> (freqValid && $stable(freqWord))
    );

endmodule

//--- lagGain/lagGain.sv
// Lag (integral) path
// Scales the error, adds it and the sweep offset into a saturating
// accumulator and reports when either limit is reached
`timescale 1ns/1ps

module lagGain
    import loopFilterPkg::*;
#(
    parameter int errWidth = 12,
    parameter int accWidth = 40
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       advance,
    input  logic                       inValid,
    input  errSample                   sample,
    input  loopConfig                  cfg,
    output logic signed [accWidth-1:0] lagAccum
);

    localparam int fracBits = accWidth - 32;

    gainCode                    lagCode;
    logic signed [accWidth-1:0] errExt;
    logic signed [accWidth-1:0] scaled;
    logic signed [accWidth-1:0] lagError;
    logic                       lagValid;
    logic                       lagClear;
    logic                       lagSync;
    logic signed [31:0]         upperLimit;
    logic signed [31:0]         lowerLimit;
    logic                       limitsLegal;
    logic signed [31:0]         sweepOffset;
    logic signed [accWidth:0]   sum;
    logic signed [32:0]         sumTop;
    logic                       clearNow;
    logic                       accumulate;
    logic                       hitUpper;
    logic                       hitLower;

    // Lag gain goes with the square of loop bandwidth, so the cut is doubled
    assign lagCode = reduceGain(cfg.lagExp, {cfg.acqTrackControl, 1'b0}, cfg.track);

    assign errExt = {{(accWidth - errWidth){sample.error[errWidth-1]}}, sample.error};

    always_comb begin
        if (lagCode == '0) begin
            scaled = '0;
        end
        else if (lagCode < 5'd3) begin
            scaled = errExt >>> (5'd3 - lagCode);
        end
        else begin
            scaled = errExt <<< (lagCode - 5'd3);
        end
    end

    // Stage 1
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagValid <= 1'b0;
            lagClear <= 1'b0;
            lagSync  <= 1'b0;
            lagError <= '0;
        end
        else if (advance) begin
            lagValid <= inValid;
            lagClear <= inValid && sample.clearAccum;
            lagSync  <= sample.carrierInSync;
            lagError <= scaled;
        end
    end

    assign upperLimit  = cfg.upperLimit;
    assign lowerLimit  = cfg.lowerLimit;
    assign limitsLegal = upperLimit >= lowerLimit;

    // One guard bit so the limit test sees the true sign of the sum
    assign sum = {lagAccum[accWidth-1], lagAccum} + {lagError[accWidth-1], lagError}
               + {{(accWidth - 31){sweepOffset[31]}}, sweepOffset};
    assign sumTop = sum[accWidth:fracBits];

    // A clearing sample zeroes the accumulator as it enters and adds nothing later
    assign clearNow   = advance && inValid && sample.clearAccum;
    assign accumulate = advance && lagValid && !lagClear;

    // Stage 2
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagAccum <= '0;
            hitUpper <= 1'b0;
            hitLower <= 1'b0;
        end
        else if (clearNow) begin
            lagAccum <= '0;
            hitUpper <= 1'b0;
            hitLower <= 1'b0;
        end
        else if (accumulate) begin
            if (!limitsLegal) begin
                // Crossed limits freeze the accumulator
                hitUpper <= 1'b0;
                hitLower <= 1'b0;
            end
            else if (sumTop >= upperLimit) begin
                lagAccum <= {upperLimit, {fracBits{1'b0}}};
                hitUpper <= 1'b1;
                hitLower <= 1'b0;
            end
            else if (sumTop <= lowerLimit) begin
                lagAccum <= {lowerLimit, {fracBits{1'b1}}};
                hitUpper <= 1'b0;
                hitLower <= 1'b1;
            end
            else begin
                lagAccum <= sum[accWidth-1:0];
                hitUpper <= 1'b0;
                hitLower <= 1'b0;
            end
        end
    end

    sweepControl sweep_i (
        .clk          (clk),
        .reset        (reset),
        .step         (advance && lagValid),
        .sweepEnable  (cfg.sweepEnable),
        .carrierInSync(lagSync),
        .sweepRateMag (cfg.sweepRateMag),
        .hitUpper     (hitUpper),
        .hitLower     (hitLower),
        .sweepOffset  (sweepOffset)
    );

    // After any accumulation with sane limits the result sits inside the limits it used
    accumInLimits: assert property (
        @(posedge clk) disable iff (reset)
        (accumulate && !clearNow && limitsLegal) |=>
            ($signed(lagAccum[accWidth-1:fracBits]) <= $past(upperLimit)) &&
            ($signed(lagAccum[accWidth-1:fracBits]) >= $past(lowerLimit))
    );

endmodule

//--- lagGain/sweepControl.sv
// Frequency sweep control
// Ramps the lag accumulator up or down until sync, reversing at each limit
`timescale 1ns/1ps

module sweepControl
    import loopFilterPkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               step,
    input  logic               sweepEnable,
    input  logic               carrierInSync,
    input  logic [31:0]        sweepRateMag,
    input  logic               hitUpper,
    input  logic               hitLower,
    output logic signed [31:0] sweepOffset
);

    sweepState          state;
    logic               sweepingUp;
    logic signed [31:0] upRate;
    logic signed [31:0] downRate;

    assign upRate   = sweepRateMag;
    assign downRate = -sweepRateMag;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= sweepOff;
            sweepOffset <= '0;
            sweepingUp  <= 1'b1;
        end
        else if (step) begin
            if (!sweepEnable) begin
                state       <= sweepOff;
                sweepOffset <= '0;
                sweepingUp  <= 1'b1;
            end
            else if (carrierInSync) begin
                state       <= sweepOff;
                sweepOffset <= '0;
                // Keep the direction for when sync is lost again
                if (state == sweepUp) begin
                    sweepingUp <= 1'b1;
                end
                else if (state == sweepDown) begin
                    sweepingUp <= 1'b0;
                end
            end
            else begin
                case (state)
                    sweepOff: begin
                        state       <= sweepingUp ? sweepUp : sweepDown;
                        sweepOffset <= sweepingUp ? upRate : downRate;
                    end
                    sweepUp: begin
                        if (hitUpper) begin
                            state       <= sweepDown;
                            sweepOffset <= downRate;
                        end
                        else begin
                            sweepOffset <= upRate;
                        end
                    end
                    sweepDown: begin
                        if (hitLower) begin
                            state       <= sweepUp;
                            sweepOffset <= upRate;
                        end
                        else begin
                            sweepOffset <= downRate;
                        end
                    end
                    default: begin
                        state       <= sweepOff;
                        sweepOffset <= '0;
                        sweepingUp  <= 1'b1;
                    end
                endcase
            end
        end
    end

    stateOneHot: assert property (@(posedge clk) disable iff (reset) $onehot(state));

endmodule

//--- design/leadGain.sv
// Lead (proportional) path
// Scales each error sample by a power of two selected by the lead gain code
`timescale 1ns/1ps

module leadGain
    import loopFilterPkg::*;
#(
    parameter int errWidth = 12,
    parameter int accWidth = 40
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       advance,
    input  logic signed [errWidth-1:0] error,
    input  gainCode                    leadExp,
    input  logic [1:0]                 acqTrackControl,
    input  logic                       track,
    output logic signed [accWidth-1:0] leadTerm
);

    gainCode                    leadCode;
    logic signed [accWidth-1:0] errExt;
    logic signed [accWidth-1:0] scaled;

    // Loop bandwidth cut applies once to the lead term
    assign leadCode = reduceGain(leadExp, {1'b0, acqTrackControl}, track);

    assign errExt = {{(accWidth - errWidth){error[errWidth-1]}}, error};

    always_comb begin
        if (leadCode == '0) begin
            scaled = '0;
        end
        // Codes 1 and 2 are fractional gains
        else if (leadCode < 5'd3) begin
            scaled = errExt >>> (5'd3 - leadCode);
        end
        else begin
            scaled = errExt <<< (leadCode - 5'd3);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            leadTerm <= '0;
        end
        else if (advance) begin
            leadTerm <= scaled;
        end
    end

endmodule

//--- common/loopFilterPkg.sv
// Loop filter shared types
// Configuration word, error sample, gain code and sweep state for the
// carrier-recovery loop filter
package loopFilterPkg;

    // Shift code, 0 is zero gain, g scales by 2**(g-3)
    typedef logic [4:0] gainCode;

    typedef struct packed {
        gainCode            leadExp;
        gainCode            lagExp;
        logic [1:0]         acqTrackControl;
        logic               track;
        // Compared against the accumulator without its fraction bits
        logic signed [31:0] upperLimit;
        logic signed [31:0] lowerLimit;
        logic               sweepEnable;
        logic [31:0]        sweepRateMag;
    } loopConfig;

    typedef struct packed {
        logic signed [11:0] error;
        logic               carrierInSync;
        logic               clearAccum;
    } errSample;

    typedef enum logic [2:0] {
        sweepOff  = 3'b001,
        sweepUp   = 3'b010,
        sweepDown = 3'b100
    } sweepState;

    // Effective gain code in track mode, floored at 1 when the cut goes too far
    function automatic gainCode reduceGain(gainCode exp, logic [2:0] cut, logic track);
        logic [5:0] diff;
        diff = {1'b0, exp} - {3'b000, cut};
        if (!track) begin
            return exp;
        end
        if (diff[5]) begin
            return gainCode'(1);
        end
        return diff[4:0];
    endfunction

endpackage
